//--- Bender.yml
package:
  name: arp_eth_tx

sources:
  - source/arp_tx_pkg.sv
  - source/arp_frame_capture.sv
  - source/arp_hdr_serializer.sv
  - source/axis_skid_buffer.sv
  - source/arp_eth_tx.sv
  - target: simulation
    files:
      - sim/arp_eth_tx_tb.sv

//--- arp_eth_tx.f
source/arp_tx_pkg.sv
source/arp_frame_capture.sv
source/arp_hdr_serializer.sv
source/axis_skid_buffer.sv
source/arp_eth_tx.sv
sim/arp_eth_tx_tb.sv

//--- sim/arp_eth_tx_tb.sv
module arp_eth_tx_tb;
    import arp_tx_pkg::*;

    localparam int TIMEOUT_CYCLES = 300;
    localparam int RANDOM_FRAMES  = 12;

    logic       clk;
    logic       reset;
    logic       frame_valid;
    eth_hdr_t   frame_eth_hdr;
    arp_req_t   frame_arp_req;
    logic       frame_ready;
    logic       eth_hdr_valid;
    eth_hdr_t   eth_hdr;
    logic       eth_hdr_ready;
    logic       payload_valid;
    axis_beat_t payload;
    logic       payload_ready;
    logic       busy;

    int hdr_mode;      // 0 always ready, 1 random, 2 held low
    int payload_mode;  // 0 always ready, 1 random
    int value_errors;
    int protocol_errors;
    int timeouts;
    bit aborted;
    int frames_sent;
    int beats_seen;

    eth_hdr_t   exp_hdr_q[$];
    axis_beat_t exp_beat_q[$];

    eth_hdr_t hdr_a, hdr_b;
    arp_req_t req_a, req_b;

    arp_eth_tx arp_eth_tx_inst (
        .clk             (clk),
        .reset           (reset),
        .frame_valid_i   (frame_valid),
        .frame_eth_hdr_i (frame_eth_hdr),
        .frame_arp_req_i (frame_arp_req),
        .frame_ready_o   (frame_ready),
        .eth_hdr_valid_o (eth_hdr_valid),
        .eth_hdr_o       (eth_hdr),
        .eth_hdr_ready_i (eth_hdr_ready),
        .payload_valid_o (payload_valid),
        .payload_o       (payload),
        .payload_ready_i (payload_ready),
        .busy_o          (busy)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // ARP payload in wire order, most significant byte of each field first
    function automatic logic [8*ARP_HDR_BYTES-1:0] ref_arp_payload(input arp_req_t req);
        return {req.htype, req.ptype, 8'd6, 8'd4, req.oper, req.sha, req.spa, req.tha, req.tpa};
    endfunction

    task automatic push_expected(input eth_hdr_t hdr, input arp_req_t req);
        logic [8*ARP_HDR_BYTES-1:0] bytes;
        axis_beat_t beat;
        bytes = ref_arp_payload(req);
        exp_hdr_q.push_back(hdr);
        for (int i = 0; i < ARP_HDR_BYTES; i++) begin
            beat.data = bytes[8*(ARP_HDR_BYTES-1-i) +: 8];
            beat.last = (i == ARP_HDR_BYTES - 1);
            exp_beat_q.push_back(beat);
        end
        frames_sent++;
    endtask

    task automatic make_frame(output eth_hdr_t hdr, output arp_req_t req);
        hdr.dest_mac = {16'($urandom), $urandom};
        hdr.src_mac  = {16'($urandom), $urandom};
        hdr.eth_type = 16'h0806;
        req.htype    = 16'($urandom);
        req.ptype    = 16'($urandom);
        req.oper     = 16'($urandom);
        req.sha      = {16'($urandom), $urandom};
        req.spa      = $urandom;
        req.tha      = {16'($urandom), $urandom};
        req.tpa      = $urandom;
    endtask

    task automatic check_low(input string name, input logic actual);
        assert (actual === 1'b0) else begin
            $display("ERROR t=%0t %s expected 0 got %b", $time, name, actual);
            value_errors++;
        end
    endtask

    task automatic wait_frame_ready(input string what);
        int n;
        n = 0;
        while (!aborted && !frame_ready) begin
            @(posedge clk);
            n++;
            if (n > TIMEOUT_CYCLES) begin
                $display("Timeout: frame_ready_o did not rise %s", what);
                timeouts++;
                aborted = 1'b1;
            end
        end
    endtask

    // Caller is just past a rising edge
    task automatic send_frame(input eth_hdr_t hdr, input arp_req_t req);
        int n;
        bit accepted;
        n = 0;
        accepted = 1'b0;
        frame_valid   <= 1'b1;
        frame_eth_hdr <= hdr;
        frame_arp_req <= req;
        while (!aborted && !accepted) begin
            @(posedge clk);
            if (frame_ready) begin  // Valid was high on this edge
                push_expected(hdr, req);
                frame_valid <= 1'b0;
                accepted = 1'b1;
            end
            n++;
            if (!accepted && n > TIMEOUT_CYCLES) begin
                $display("Timeout: frame was not accepted by the DUT");
                timeouts++;
                aborted = 1'b1;
            end
        end
        if (accepted) begin
            @(posedge clk);  // Busy from the cycle after acceptance
            assert (busy === 1'b1) else begin
                $display("ERROR t=%0t busy_o expected 1 got %b", $time, busy);
                value_errors++;
            end
        end
    endtask

    task automatic wait_drain();
        int n;
        n = 0;
        while (!aborted && (exp_hdr_q.size() != 0 || exp_beat_q.size() != 0)) begin
            @(posedge clk);
            n++;
            if (n > 4 * TIMEOUT_CYCLES) begin
                $display("Timeout: expected headers or payload bytes did not all arrive");
                timeouts++;
                aborted = 1'b1;
            end
        end
    endtask

    always @(posedge clk) begin
        case (hdr_mode)
            0:       eth_hdr_ready <= 1'b1;
            1:       eth_hdr_ready <= ($urandom % 4) != 0;
            default: eth_hdr_ready <= 1'b0;
        endcase
        payload_ready <= (payload_mode == 0) ? 1'b1 : 1'($urandom % 2);
    end

    always @(posedge clk) begin : hdr_check
        eth_hdr_t exp;
        if (!reset && eth_hdr_valid && eth_hdr_ready) begin
            assert (exp_hdr_q.size() > 0) else begin
                $display("Ethernet header transferred with no accepted frame pending");
                protocol_errors++;
            end
            if (exp_hdr_q.size() > 0) begin
                exp = exp_hdr_q.pop_front();
                assert (eth_hdr == exp) else begin
                    $display("ERROR t=%0t eth_hdr_o expected %h got %h", $time, exp, eth_hdr);
                    value_errors++;
                end
            end
        end
    end

    always @(posedge clk) begin : payload_check
        axis_beat_t exp;
        logic       stall_seen;
        axis_beat_t stall_beat;
        if (reset) begin
            stall_seen = 1'b0;
        end else begin
            if (stall_seen) begin  // Held beat must not move
                assert (payload_valid && payload == stall_beat) else begin
                    $display("ERROR t=%0t payload_o held expected %h got %h", $time,
                             stall_beat, payload);
                    value_errors++;
                end
            end
            stall_seen = payload_valid && !payload_ready;
            stall_beat = payload;
            if (payload_valid && payload_ready) begin
                beats_seen++;
                assert (exp_beat_q.size() > 0) else begin
                    $display("Payload byte transferred beyond the expected frames");
                    protocol_errors++;
                end
                if (exp_beat_q.size() > 0) begin
                    exp = exp_beat_q.pop_front();
                    assert (payload.data == exp.data) else begin
                        $display("ERROR t=%0t payload_o.data expected %h got %h", $time,
                                 exp.data, payload.data);
                        value_errors++;
                    end
                    assert (payload.last == exp.last) else begin
                        $display("ERROR t=%0t payload_o.last expected %b got %b", $time,
                                 exp.last, payload.last);
                        value_errors++;
                    end
                end
            end
        end
    end

    initial begin
        void'($urandom(93490));
        reset         = 1'b1;
        frame_valid   = 1'b0;
        frame_eth_hdr = '0;
        frame_arp_req = '0;
        eth_hdr_ready = 1'b0;
        payload_ready = 1'b0;
        hdr_mode      = 0;
        payload_mode  = 0;
        aborted       = 1'b0;

        for (int c = 0; c < 3; c++) begin
            @(posedge clk);
            if (c > 0) begin  // Registers settle on the first edge
                check_low("eth_hdr_valid_o", eth_hdr_valid);
                check_low("payload_valid_o", payload_valid);
                check_low("busy_o", busy);
            end
        end
        reset <= 1'b0;
        @(posedge clk);
        check_low("eth_hdr_valid_o", eth_hdr_valid);
        check_low("payload_valid_o", payload_valid);
        check_low("busy_o", busy);
        check_low("frame_ready_o", frame_ready);
        wait_frame_ready("after reset");

        // Two frames back to back, no back-pressure
        for (int f = 0; f < 2; f++) begin
            make_frame(hdr_a, req_a);
            send_frame(hdr_a, req_a);
        end

        payload_mode <= 1;
        for (int f = 0; f < RANDOM_FRAMES; f++) begin
            if (f == RANDOM_FRAMES / 2) begin
                hdr_mode <= 1;
            end
            make_frame(hdr_a, req_a);
            send_frame(hdr_a, req_a);
            repeat ($urandom % 3) @(posedge clk);
        end
        wait_drain();

        // Header held off, the next frame must stay out
        hdr_mode <= 2;
        repeat (2) @(posedge clk);
        make_frame(hdr_a, req_a);
        send_frame(hdr_a, req_a);
        make_frame(hdr_b, req_b);
        frame_valid   <= 1'b1;
        frame_eth_hdr <= hdr_b;
        frame_arp_req <= req_b;
        repeat (3 * ARP_HDR_BYTES) begin
            @(posedge clk);
            assert (!frame_ready && eth_hdr_valid) else begin
                $display("Frame ready rose or header dropped while eth_hdr_ready_i was low");
                protocol_errors++;
            end
        end
        hdr_mode <= 1;
        send_frame(hdr_b, req_b);

        for (int f = 0; f < 4; f++) begin
            make_frame(hdr_a, req_a);
            send_frame(hdr_a, req_a);
        end
        wait_drain();

        assert (beats_seen == frames_sent * ARP_HDR_BYTES) else begin
            $display("Payload transfer count does not match 28 bytes per accepted frame");
            protocol_errors++;
        end

        $display("Frames %0d, beats %0d, value errors %0d, protocol errors %0d, timeouts %0d",
                 frames_sent, beats_seen, value_errors, protocol_errors, timeouts);
        if (value_errors == 0 && protocol_errors == 0 && timeouts == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- source/arp_eth_tx.sv
module arp_eth_tx (
    input  logic                   clk,
    input  logic                   reset,

    // Frame input
    input  logic                   frame_valid_i,
    input  arp_tx_pkg::eth_hdr_t   frame_eth_hdr_i,
    input  arp_tx_pkg::arp_req_t   frame_arp_req_i,
    output logic                   frame_ready_o,

    // Ethernet header output
    output logic                   eth_hdr_valid_o,
    output arp_tx_pkg::eth_hdr_t   eth_hdr_o,
    input  logic                   eth_hdr_ready_i,

    // ARP payload stream
    output logic                   payload_valid_o,
    output arp_tx_pkg::axis_beat_t payload_o,
    input  logic                   payload_ready_i,

    output logic                   busy_o
);
    import arp_tx_pkg::*;

    logic       start;
    arp_hdr_u   arp_hdr;
    logic       ser_busy;
    axis_beat_t beat;
    logic       beat_valid;
    logic       beat_ready;

    assign busy_o = ser_busy;

    arp_frame_capture frame_capture_inst (
        .clk             (clk),
        .reset           (reset),
        .frame_valid_i   (frame_valid_i),
        .eth_hdr_i       (frame_eth_hdr_i),
        .arp_req_i       (frame_arp_req_i),
        .frame_ready_o   (frame_ready_o),
        .eth_hdr_valid_o (eth_hdr_valid_o),
        .eth_hdr_o       (eth_hdr_o),
        .eth_hdr_ready_i (eth_hdr_ready_i),
        .ser_busy_i      (ser_busy),
        .start_o         (start),
        .arp_hdr_o       (arp_hdr)
    );

    arp_hdr_serializer hdr_serializer_inst (
        .clk          (clk),
        .reset        (reset),
        .start_i      (start),
        .arp_hdr_i    (arp_hdr),
        .beat_o       (beat),
        .beat_valid_o (beat_valid),
        .beat_ready_i (beat_ready),
        .busy_o       (ser_busy)
    );

    axis_skid_buffer skid_buffer_inst (
        .clk         (clk),
        .reset       (reset),
        .in_beat_i   (beat),
        .in_valid_i  (beat_valid),
        .in_ready_o  (beat_ready),
        .out_beat_o  (payload_o),
        .out_valid_o (payload_valid_o),
        .out_ready_i (payload_ready_i)
    );

endmodule

//--- source/arp_frame_capture.sv
module arp_frame_capture (
    input  logic                   clk,
    input  logic                   reset,

    input  logic                   frame_valid_i,
    input  arp_tx_pkg::eth_hdr_t   eth_hdr_i,
    input  arp_tx_pkg::arp_req_t   arp_req_i,
    output logic                   frame_ready_o,

    output logic                   eth_hdr_valid_o,
    output arp_tx_pkg::eth_hdr_t   eth_hdr_o,
    input  logic                   eth_hdr_ready_i,

    input  logic                   ser_busy_i,

    output logic                   start_o,
    output arp_tx_pkg::arp_hdr_u   arp_hdr_o
);
    import arp_tx_pkg::*;

    logic        accept;
    logic        hdr_valid_q, hdr_valid_d;
    logic        ready_q, ready_d;
    eth_hdr_t    eth_hdr_q;
    arp_hdr_u    arp_hdr_q;
    arp_fields_t fields;

    assign accept          = frame_valid_i && ready_q;
    assign start_o         = accept;  // Serializer starts on the accepting edge
    assign frame_ready_o   = ready_q;
    assign eth_hdr_valid_o = hdr_valid_q;
    assign eth_hdr_o       = eth_hdr_q;
    assign arp_hdr_o       = arp_hdr_q;

    always_comb begin
        fields.htype = arp_req_i.htype;
        fields.ptype = arp_req_i.ptype;
        fields.hlen  = ARP_HLEN;
        fields.plen  = ARP_PLEN;
        fields.oper  = arp_req_i.oper;
        fields.sha   = arp_req_i.sha;
        fields.spa   = arp_req_i.spa;
        fields.tha   = arp_req_i.tha;
        fields.tpa   = arp_req_i.tpa;
    end

    always_comb begin
        hdr_valid_d = hdr_valid_q && !eth_hdr_ready_i;
        if (accept) begin
            hdr_valid_d = 1'b1;
        end
        // Next frame only once header is gone and payload is handed over
        ready_d = !hdr_valid_d && !ser_busy_i;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            hdr_valid_q <= 1'b0;
            ready_q     <= 1'b0;
        end else begin
            hdr_valid_q <= hdr_valid_d;
            ready_q     <= ready_d;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            eth_hdr_q        <= eth_hdr_i;
            arp_hdr_q.fields <= fields;
        end
    end

    // Serializer only turns busy through a start from here
    a_ready_only_when_idle: assert property (@(posedge clk) disable iff (reset)
        frame_ready_o |-> !ser_busy_i);

endmodule

//--- source/arp_hdr_serializer.sv
module arp_hdr_serializer (
    input  logic                   clk,
    input  logic                   reset,

    input  logic                   start_i,
    input  arp_tx_pkg::arp_hdr_u   arp_hdr_i,

    output arp_tx_pkg::axis_beat_t beat_o,
    output logic                   beat_valid_o,
    input  logic                   beat_ready_i,

    output logic                   busy_o
);
    import arp_tx_pkg::*;

    localparam logic [ARP_PTR_W-1:0] LAST_PTR = ARP_PTR_W'(ARP_HDR_BYTES - 1);

    logic [ARP_PTR_W-1:0] ptr_q;
    logic                 sending_q;
    logic                 at_last;
    logic                 step;

    assign at_last = (ptr_q == LAST_PTR);
    assign step    = sending_q && beat_ready_i;  // One byte per ready cycle

    // Byte view of the captured header
    assign beat_o.data  = arp_hdr_i.bytes[ptr_q];
    assign beat_o.last  = at_last;
    assign beat_valid_o = step;
    assign busy_o       = sending_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            ptr_q     <= '0;
            sending_q <= 1'b0;
        end else if (start_i) begin
            ptr_q     <= '0;
            sending_q <= 1'b1;
        end else if (step) begin
            ptr_q <= ptr_q + 1'b1;
            if (at_last) begin
                sending_q <= 1'b0;  // 28th byte handed over
            end
        end
    end

    a_ptr_in_range: assert property (@(posedge clk) disable iff (reset)
        sending_q |-> (ptr_q <= LAST_PTR));

    // Capture must hold off a new frame until the last byte has left
    a_no_start_while_sending: assert property (@(posedge clk) disable iff (reset)
        !(start_i && sending_q));

endmodule

//--- source/arp_tx_pkg.sv
package arp_tx_pkg;

    // ARP over Ethernet/IPv4 header geometry
    localparam int ARP_HDR_BYTES = 28;
    localparam logic [7:0] ARP_HLEN = 8'd6;  // MAC length
    localparam logic [7:0] ARP_PLEN = 8'd4;  // IPv4 length
    localparam int ARP_PTR_W = 5;            // Enough for bytes 0..27

    typedef struct packed {
        logic [47:0] dest_mac;
        logic [47:0] src_mac;
        logic [15:0] eth_type;
    } eth_hdr_t;

    // Fields supplied by the user, lengths are inserted by the DUT
    typedef struct packed {
        logic [15:0] htype;
        logic [15:0] ptype;
        logic [15:0] oper;
        logic [47:0] sha;
        logic [31:0] spa;
        logic [47:0] tha;
        logic [31:0] tpa;
    } arp_req_t;

    // Wire order, first field in the most significant bits
    typedef struct packed {
        logic [15:0] htype;
        logic [15:0] ptype;
        logic [7:0]  hlen;
        logic [7:0]  plen;
        logic [15:0] oper;
        logic [47:0] sha;
        logic [31:0] spa;
        logic [47:0] tha;
        logic [31:0] tpa;
    } arp_fields_t;

    // Same 224 bits seen as fields or as wire bytes
    typedef union packed {
        arp_fields_t fields;
        logic [0:ARP_HDR_BYTES-1][7:0] bytes;  // Entry 0 goes out first
    } arp_hdr_u;

    // One byte of payload stream
    typedef struct packed {
        logic [7:0] data;
        logic       last;
    } axis_beat_t;

endpackage

//--- source/axis_skid_buffer.sv
module axis_skid_buffer (
    input  logic                   clk,
    input  logic                   reset,

    input  arp_tx_pkg::axis_beat_t in_beat_i,
    input  logic                   in_valid_i,
    output logic                   in_ready_o,

    output arp_tx_pkg::axis_beat_t out_beat_o,
    output logic                   out_valid_o,
    input  logic                   out_ready_i
);
    import arp_tx_pkg::*;

    axis_beat_t out_q;
    axis_beat_t tmp_q;
    logic       out_valid_q, out_valid_d;
    logic       tmp_valid_q, tmp_valid_d;
    logic       in_ready_q;
    logic       in_ready_d;
    logic       load_out;     // Input straight to output
    logic       load_tmp;     // Input parked in temp
    logic       tmp_to_out;

    assign in_ready_o  = in_ready_q;
    assign out_beat_o  = out_q;
    assign out_valid_o = out_valid_q;

    // Registered ready, temp catches the beat already in flight
    assign in_ready_d = out_ready_i || (!tmp_valid_q && !out_valid_q);

    always_comb begin
        out_valid_d = out_valid_q;
        tmp_valid_d = tmp_valid_q;
        load_out    = 1'b0;
        load_tmp    = 1'b0;
        tmp_to_out  = 1'b0;

        if (in_ready_q) begin
            if (out_ready_i || !out_valid_q) begin
                out_valid_d = in_valid_i;
                load_out    = 1'b1;
            end else begin
                tmp_valid_d = in_valid_i;
                load_tmp    = 1'b1;
            end
        end else if (out_ready_i) begin
            out_valid_d = tmp_valid_q;
            tmp_valid_d = 1'b0;
            tmp_to_out  = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid_q <= 1'b0;
            tmp_valid_q <= 1'b0;
            in_ready_q  <= 1'b0;
        end else begin
            out_valid_q <= out_valid_d;
            tmp_valid_q <= tmp_valid_d;
            in_ready_q  <= in_ready_d;
        end
    end

    always_ff @(posedge clk) begin
        if (load_out) begin
            out_q <= in_beat_i;
        end else if (tmp_to_out) begin
            out_q <= tmp_q;
        end
        if (load_tmp) begin
            tmp_q <= in_beat_i;
        end
    end

    a_out_stable: assert property (@(posedge clk) disable iff (reset)
        (out_valid_o && !out_ready_i) |=> (out_valid_o && $stable(out_beat_o)));

endmodule
